// File: frame_pkg.sv
package frame_pkg;

  // one byte of the stream.
  typedef logic [7:0] byte_t;

  // statistics counters wrap silently.
  typedef logic [15:0] count_t;

  // frame store sizing.
  localparam int FIFO_ADDR_WIDTH = 6;
  localparam int FIFO_DEPTH = 2 ** FIFO_ADDR_WIDTH;

  // extra msb tells full from empty when the address bits match.
  typedef logic [FIFO_ADDR_WIDTH:0] fifo_ptr_t;

  // the stripper either has nothing or one byte held back.
  typedef enum logic {
    strip_empty   = 1'b0,
    strip_holding = 1'b1
  } strip_state_t;

endpackage

// File: frame_rx_check.sv
`timescale 1ns/1ps

module frame_rx_check
  import frame_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  byte_t  in_data,
  input  logic   in_valid,
  input  logic   in_last,
  output logic   in_ready,
  output byte_t  chk_data,
  output logic   chk_valid,
  output logic   chk_last,
  output logic   chk_bad,
  output count_t bad_count
);

  byte_t sum_q;       // sum of the bytes seen so far in this frame.
  logic  first_q;     // next byte opens a frame.
  logic  accept;
  logic  frame_bad;

  // the frame fifo takes a byte every cycle, so the output register
  // is always either empty or being drained.
  assign in_ready = 1'b1;

  assign accept = in_valid & in_ready;

  // a one-byte frame carries only a checksum and no payload.
  assign frame_bad = first_q | (in_data != sum_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_valid <= 1'b0;
      sum_q     <= '0;
      first_q   <= 1'b1;
      bad_count <= '0;
    end else begin
      chk_valid <= accept;
      if (accept) begin
        if (in_last) begin
          sum_q   <= '0;
          first_q <= 1'b1;
          if (frame_bad) begin
            bad_count <= bad_count + 1'b1;
          end
        end else begin
          sum_q   <= sum_q + in_data; // modulo 256.
          first_q <= 1'b0;
        end
      end
    end
  end

  // payload side of the register slice.
  always_ff @(posedge clk) begin
    if (accept) begin
      chk_data <= in_data;
      chk_last <= in_last;
      chk_bad  <= in_last & frame_bad;
    end
  end

endmodule

// File: frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo
  import frame_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  byte_t  chk_data,
  input  logic   chk_valid,
  input  logic   chk_last,
  input  logic   chk_bad,
  output byte_t  fifo_data,
  output logic   fifo_valid,
  output logic   fifo_last,
  input  logic   fifo_ready,
  output count_t drop_count
);

  // each entry is the last marker above the data byte.
  logic [$bits(byte_t):0] mem [FIFO_DEPTH];

  fifo_ptr_t wr_ptr;      // end of the last committed frame.
  fifo_ptr_t wr_ptr_cur;  // next write inside the frame being stored.
  fifo_ptr_t wr_ptr_rd;   // committed pointer as seen by the read side.
  fifo_ptr_t rd_ptr;
  logic      drop_q;      // rest of the current frame is discarded.

  logic full_cur;
  logic empty;
  logic out_free;
  logic load;

  // the frame in progress has caught up with the read pointer.
  assign full_cur = (wr_ptr_cur[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                    (wr_ptr_cur[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);

  assign empty    = (wr_ptr_rd == rd_ptr);
  assign out_free = ~fifo_valid | fifo_ready;
  assign load     = out_free & ~empty;

  // the write side never stalls.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      drop_q     <= 1'b0;
      drop_count <= '0;
    end else if (chk_valid) begin
      if (full_cur || drop_q) begin
        drop_q <= 1'b1;
        if (chk_last) begin
          wr_ptr_cur <= wr_ptr;   // roll back to the commit point.
          drop_q     <= 1'b0;
          if (!chk_bad) begin
            drop_count <= drop_count + 1'b1; // bad frames are counted upstream.
          end
        end
      end else begin
        wr_ptr_cur <= wr_ptr_cur + 1'b1;
        if (chk_last) begin
          if (chk_bad) begin
            wr_ptr_cur <= wr_ptr;
          end else begin
            wr_ptr <= wr_ptr_cur + 1'b1; // publish the whole frame.
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (chk_valid && !full_cur && !drop_q) begin
      mem[wr_ptr_cur[FIFO_ADDR_WIDTH-1:0]] <= {chk_last, chk_data};
    end
  end

  // one cycle of delay between commit and the read side.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_rd <= '0;
    end else begin
      wr_ptr_rd <= wr_ptr;
    end
  end

  // read side with a registered output.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr     <= '0;
      fifo_valid <= 1'b0;
    end else if (out_free) begin
      fifo_valid <= ~empty;
      if (!empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      {fifo_last, fifo_data} <= mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
    end
  end

endmodule

// File: frame_tx_strip.sv
`timescale 1ns/1ps

module frame_tx_strip
  import frame_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  byte_t fifo_data,
  input  logic  fifo_valid,
  input  logic  fifo_last,
  output logic  fifo_ready,
  output byte_t out_data,
  output logic  out_valid,
  output logic  out_last,
  input  logic  out_ready
);

  strip_state_t state_q;
  byte_t        hold_q;     // newest byte of the frame, not yet known to be payload.
  logic         out_free;
  logic         take;

  assign out_free = ~out_valid | out_ready;

  // with nothing held an arriving byte only fills the hold register.
  assign fifo_ready = (state_q == strip_empty) | out_free;
  assign take       = fifo_valid & fifo_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= strip_empty;
      out_valid <= 1'b0;
    end else begin
      if (out_ready) begin
        out_valid <= 1'b0;
      end
      if (take) begin
        case (state_q)
          strip_empty: begin
            if (!fifo_last) begin
              state_q <= strip_holding;
            end // a lone last byte is a checksum with nothing to carry.
          end
          strip_holding: begin
            out_valid <= 1'b1; // the held byte is payload.
            if (fifo_last) begin
              state_q <= strip_empty; // checksum byte is consumed here.
            end
          end
          default: begin
            state_q <= strip_empty;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      if (state_q == strip_holding) begin
        out_data <= hold_q;
        out_last <= fifo_last; // last moves onto the final payload byte.
      end
      hold_q <= fifo_data;
    end
  end

endmodule

// File: frame_buffer_top.sv
`timescale 1ns/1ps

module frame_buffer_top
  import frame_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  byte_t  in_data,
  input  logic   in_valid,
  input  logic   in_last,
  output logic   in_ready,
  output byte_t  out_data,
  output logic   out_valid,
  output logic   out_last,
  input  logic   out_ready,
  output count_t bad_count,
  output count_t drop_count
);

  byte_t chk_data;
  logic  chk_valid;
  logic  chk_last;
  logic  chk_bad;

  byte_t fifo_data;
  logic  fifo_valid;
  logic  fifo_last;
  logic  fifo_ready;

  frame_rx_check frame_rx_check_i (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .in_ready  (in_ready),
    .chk_data  (chk_data),
    .chk_valid (chk_valid),
    .chk_last  (chk_last),
    .chk_bad   (chk_bad),
    .bad_count (bad_count)
  );

  frame_fifo frame_fifo_i (
    .clk        (clk),
    .rst        (rst),
    .chk_data   (chk_data),
    .chk_valid  (chk_valid),
    .chk_last   (chk_last),
    .chk_bad    (chk_bad),
    .fifo_data  (fifo_data),
    .fifo_valid (fifo_valid),
    .fifo_last  (fifo_last),
    .fifo_ready (fifo_ready),
    .drop_count (drop_count)
  );

  frame_tx_strip frame_tx_strip_i (
    .clk        (clk),
    .rst        (rst),
    .fifo_data  (fifo_data),
    .fifo_valid (fifo_valid),
    .fifo_last  (fifo_last),
    .fifo_ready (fifo_ready),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .out_ready  (out_ready)
  );

endmodule

// File: tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

byte_t frame_q[$];    // bytes of the frame being sent, checksum last.
byte_t exp_bytes[$];  // payloads still owed by the DUT, end to end.
int    exp_lens[$];   // payload length of each owed frame.
byte_t got_q[$];      // payload of the frame now coming out.

// random payload of len - 1 bytes, then the modulo-256 sum of them.
function automatic void build_frame(input int len, input bit corrupt);
  logic [31:0] r;
  byte_t       sum;
  int          i;
  sum = '0;
  frame_q.delete();
  for (i = 0; i < len - 1; i++) begin
    r = $urandom;
    frame_q.push_back(r[7:0]);
    sum = sum + r[7:0];
  end
  if (corrupt) begin
    r = $urandom;
    sum = sum ^ ((r[7:0] == 8'h00) ? 8'h5a : r[7:0]); // any nonzero flip breaks the sum.
  end
  frame_q.push_back(sum);
endfunction

// the output carries everything but the checksum byte.
function automatic void push_expected();
  int i;
  for (i = 0; i < frame_q.size() - 1; i++) begin
    exp_bytes.push_back(frame_q[i]);
  end
  exp_lens.push_back(frame_q.size() - 1);
endfunction

function automatic void drop_expected();
  byte_t discard;
  int    len;
  int    i;
  len = exp_lens.pop_front();
  for (i = 0; i < len; i++) begin
    discard = exp_bytes.pop_front();
  end
endfunction

// compares got_q with the owed payload that starts at offset.
function automatic bit matches_at(input int offset, input int len);
  bit same;
  int i;
  same = (got_q.size() == len);
  for (i = 0; same && i < len; i++) begin
    same = (got_q[i] == exp_bytes[offset + i]);
  end
  return same;
endfunction

`endif

// File: tb_frame_buffer.sv
`timescale 1ns/1ps

module tb_frame_buffer
  import frame_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int RAND_SEED       = 57887;
  localparam int N_SPACED        = 12;
  localparam int N_MIXED         = 16;
  localparam int N_BURST         = 25;
  localparam int N_FRAMES        = N_SPACED + N_MIXED + 4 + 2 * N_BURST;
  localparam int WAIT_CYCLES     = 4000;
  localparam int WATCHDOG_CYCLES = 200 * N_FRAMES + 1000;

  logic   clk;
  logic   rst;
  byte_t  in_data;
  logic   in_valid;
  logic   in_last;
  logic   in_ready;
  byte_t  out_data;
  logic   out_valid;
  logic   out_last;
  logic   out_ready;
  count_t bad_count;
  count_t drop_count;

  int    value_errors = 0;
  int    other_errors = 0;
  int    frames_delivered = 0;
  int    good_sent = 0;
  int    skipped = 0;
  int    seed_value;
  bit    skip_ok = 1'b0;       // dropped frames may be missing from the output.
  bit    random_ready = 1'b0;
  bit    stall_q = 1'b0;
  byte_t held_data;
  logic  held_last;

  `include "tb_frame_model.svh"

  frame_buffer_top frame_buffer_top_i (
    .clk        (clk),
    .rst        (rst),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_last    (in_last),
    .in_ready   (in_ready),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .out_ready  (out_ready),
    .bad_count  (bad_count),
    .drop_count (drop_count)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic next_cycle();
    @(negedge clk);
    out_ready = random_ready ? ($urandom % 4 == 0) : 1'b1;
  endtask

  task automatic go_idle(input int n);
    repeat (n) begin
      next_cycle();
      in_valid = 1'b0;
      in_last  = 1'b0;
    end
  endtask

  // leaves the last byte driven, so a following frame goes back to back.
  task automatic send_frame(input int len, input bit corrupt, input bit keep);
    int i;
    build_frame(len, corrupt);
    if (keep) begin
      push_expected();
    end
    if (!corrupt && len > 1) begin
      good_sent++;
    end
    for (i = 0; i < len; i++) begin
      next_cycle();
      in_data  = frame_q[i];
      in_valid = 1'b1;
      in_last  = (i == len - 1);
      @(posedge clk);
      while (!in_ready) @(posedge clk);
    end
  endtask

  // every good frame ends up either delivered or counted as dropped.
  task automatic wait_for_frames();
    int cycles;
    cycles = 0;
    go_idle(1);
    while (frames_delivered + drop_count < good_sent && cycles < WAIT_CYCLES) begin
      go_idle(1);
      cycles++;
    end
    if (cycles >= WAIT_CYCLES) begin
      other_errors++;
      $display("timed out waiting for the buffer to deliver or drop every frame");
    end
    go_idle(10);
  endtask

  task automatic check_frame();
    int  offset;
    int  k;
    int  i;
    bit  found;
    offset = 0;
    k      = 0;
    found  = 1'b0;
    if (exp_lens.size() == 0) begin
      other_errors++;
      $display("a frame came out while no frame was expected");
    end else if (!skip_ok) begin
      assert (got_q.size() == exp_lens[0]) else begin
        value_errors++;
        $display("FAILED out_last: expected on byte %h, got on byte %h",
                 exp_lens[0] - 1, got_q.size() - 1);
      end
      for (i = 0; i < got_q.size() && i < exp_lens[0]; i++) begin
        assert (got_q[i] == exp_bytes[i]) else begin
          value_errors++;
          $display("FAILED out_data: expected %h, got %h", exp_bytes[i], got_q[i]);
        end
      end
      drop_expected();
    end else begin
      while (!found && k < exp_lens.size()) begin
        if (matches_at(offset, exp_lens[k])) begin
          found = 1'b1;
        end else begin
          offset = offset + exp_lens[k];
          k++;
        end
      end
      assert (found) else begin
        other_errors++;
        $display("a delivered frame matches none of the frames still expected");
      end
      if (found) begin
        repeat (k + 1) drop_expected();
        skipped = skipped + k;
      end
    end
    frames_delivered++;
  endtask

  // the monitor samples outputs just before each rising edge takes effect.
  always @(posedge clk) begin
    if (rst) begin
      stall_q = 1'b0;
    end else begin
      if (stall_q) begin
        assert (out_valid) else begin
          other_errors++;
          $display("out_valid fell while a byte was waiting for out_ready");
        end
        assert (out_data == held_data && out_last == held_last) else begin
          value_errors++;
          $display("FAILED out_data/out_last: expected %h/%h, got %h/%h",
                   held_data, held_last, out_data, out_last);
        end
      end
      stall_q   = out_valid & ~out_ready;
      held_data = out_data;
      held_last = out_last;
      if (out_valid && out_ready) begin
        got_q.push_back(out_data);
        if (out_last) begin
          check_frame();
          got_q.delete();
        end
      end
    end
  end

  task automatic print_summary();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
  endtask

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("watchdog expired before the tests finished");
    print_summary();
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    int n_bad;
    int drop_base;
    int leftover;
    int i;
    seed_value = $urandom(RAND_SEED);
    n_bad     = 0;
    rst       = 1'b1;
    in_data   = '0;
    in_valid  = 1'b0;
    in_last   = 1'b0;
    out_ready = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    assert (out_valid == 1'b0 && in_ready == 1'b1) else begin
      value_errors++;
      $display("FAILED out_valid/in_ready: expected 0/1, got %h/%h", out_valid, in_ready);
    end
    assert (bad_count == 0 && drop_count == 0) else begin
      value_errors++;
      $display("FAILED bad_count/drop_count: expected 0/0, got %h/%h", bad_count, drop_count);
    end

    for (i = 0; i < N_SPACED; i++) begin
      send_frame(2 + $urandom % 19, 1'b0, 1'b1);
      go_idle(1 + $urandom % 6);
    end
    wait_for_frames();

    for (i = 0; i < N_MIXED; i++) begin
      if ($urandom % 2 == 0) begin
        send_frame(2 + $urandom % 19, 1'b0, 1'b1);
      end else if ($urandom % 3 == 0) begin
        send_frame(1, 1'b0, 1'b0); // payload-free frame.
        n_bad++;
      end else begin
        send_frame(1 + $urandom % 20, 1'b1, 1'b0);
        n_bad++;
      end
      go_idle(1 + $urandom % 3);
    end
    wait_for_frames();
    assert (bad_count == n_bad) else begin
      value_errors++;
      $display("FAILED bad_count: expected %h, got %h", n_bad, bad_count);
    end

    send_frame(FIFO_DEPTH + 8, 1'b0, 1'b0); // cannot fit even in an empty buffer.
    for (i = 0; i < 3; i++) begin
      send_frame(2 + $urandom % 19, 1'b0, 1'b1);
    end
    wait_for_frames();
    assert (drop_count == 1) else begin
      value_errors++;
      $display("FAILED drop_count: expected %h, got %h", 1, drop_count);
    end
    assert (exp_lens.size() == 0) else begin
      other_errors++;
      $display("%0d good frames never came out", exp_lens.size());
    end

    skip_ok      = 1'b1;
    random_ready = 1'b1;
    drop_base    = drop_count;
    repeat (2) begin
      for (i = 0; i < N_BURST; i++) begin
        send_frame(2 + $urandom % 19, 1'b0, 1'b1);
      end
      go_idle(20 + $urandom % 40);
    end
    wait_for_frames();
    random_ready = 1'b0;
    leftover     = exp_lens.size();
    assert (frames_delivered + drop_count == good_sent) else begin
      value_errors++;
      $display("FAILED drop_count: expected %h, got %h", good_sent - frames_delivered, drop_count);
    end
    assert (skipped + leftover == drop_count - drop_base) else begin
      other_errors++;
      $display("frames missing from the output do not agree with drop_count");
    end

    go_idle(5);
    print_summary();
    if (value_errors + other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+.
frame_pkg.sv
frame_rx_check.sv
frame_fifo.sv
frame_tx_strip.sv
frame_buffer_top.sv
tb_frame_buffer.sv
